/* project.f */
common/ctrl_pkg.sv
console/char_fifo.sv
console/console_port.sv
hw/local_ram.sv
hw/local_bus_decoder.sv
hw/wb_downsizer.sv
hw/simple_controller_top.sv
sim/tb_main.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/10ps
TOP       ?= tb_main
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* sim/tb_main.sv */
`timescale 1ns/10ps

module tb_main;

    import ctrl_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int RAM_WRITES   = 200;
    localparam int CHARS        = 40;
    localparam int UNMAPPED     = 30;
    localparam int TRANS_CYCLES = 40;   // Worst case per access including console stalls.
    localparam int NUM_TRANS    = 512 + 3 * RAM_WRITES + 3 + CHARS + 18 + 3 * UNMAPPED + 3;
    localparam int DRAIN_CYCLES = 50 + 20 * (CHARS + 17);
    localparam int MAX_CYCLES   = RESET_CYCLES + NUM_TRANS * TRANS_CYCLES + DRAIN_CYCLES;

    logic         clk;
    logic         reset;
    host_wb_req_t host_req;
    host_wb_rsp_t host_rsp;
    char_t        tx_data;
    logic         tx_valid;
    logic         tx_ready;
    logic         hold_ready;   // Forces the console sink to stall.
    int           cycle_count = 0;
    logic [31:0]  stim_lfsr = 32'h739f;
    logic [31:0]  sink_lfsr = 32'h739f;
    logic [31:0]  ram_model [1024];
    char_t        exp_q[$];
    char_t        rx_q[$];
    int           written[$];   // Host words that hold known data.

    simple_controller_top dut (
        .clk        (clk),
        .reset      (reset),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp),
        .tx_data_o  (tx_data),
        .tx_valid_o (tx_valid),
        .tx_ready_i (tx_ready)
    );

    function automatic logic [31:0] step_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1.
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = step_lfsr(stim_lfsr);
            v = {v[62:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic int pick_below(input int n);
        return int'(take_bits(20) % 64'(n));
    endfunction

    // Upper host address bits are random since they alias.
    function automatic host_adr_t alias_adr(input int a);
        logic [63:0] up;
        up = take_bits(22);
        return {up[21:0], a[14:0]};
    endfunction

    function automatic logic [9:0] ram_index(input int a, input int half);
        int w;
        w = 2 * a + half;
        return w[9:0];
    endfunction

    function automatic host_dat_t expected_read(input int a, input host_sel_t sel);
        host_dat_t v;
        v = '0;
        if (sel[3:0] != 4'h0) v[31:0] = ram_model[ram_index(a, 0)];
        if (sel[7:4] != 4'h0) v[63:32] = ram_model[ram_index(a, 1)];
        return v;
    endfunction

    function automatic void merge_write(input int a, input host_dat_t dat, input host_sel_t sel);
        for (int b = 0; b < 8; b++) begin
            if (sel[b]) ram_model[ram_index(a, b / 4)][8 * (b % 4) +: 8] = dat[8 * b +: 8];
        end
    endfunction

    function automatic int expected_level();
        return exp_q.size() - rx_q.size();
    endfunction

    // Level in bits 4 to 0, full at bit 8, empty at bit 9.
    function automatic logic [31:0] status_word(input int level);
        logic [31:0] v;
        v = 32'(level);
        v[8] = (level == 16);
        v[9] = (level == 0);
        return v;
    endfunction

    task automatic expect_equal(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic start_access(input host_adr_t adr, input host_dat_t dat,
                                input host_sel_t sel, input logic we);
        @(posedge clk);
        host_req.adr <= adr;
        host_req.dat <= dat;
        host_req.sel <= sel;
        host_req.we  <= we;
        host_req.stb <= 1'b1;
    endtask

    task automatic finish_access(output host_dat_t rdat);
        do begin
            @(posedge clk);
        end while (!host_rsp.ack);
        rdat = host_rsp.dat;   // Data is valid with the ack.
        host_req.stb <= 1'b0;
    endtask

    task automatic write_word(input host_adr_t adr, input host_dat_t dat, input host_sel_t sel);
        host_dat_t ignored;
        start_access(adr, dat, sel, 1'b1);
        finish_access(ignored);
    endtask

    task automatic read_word(input host_adr_t adr, input host_sel_t sel, output host_dat_t rdat);
        start_access(adr, take_bits(64), sel, 1'b0);
        finish_access(rdat);
    endtask

    task automatic send_char(input char_t ch);
        host_dat_t dat;
        dat = take_bits(64);
        dat[7:0] = ch;
        exp_q.push_back(ch);
        write_word(alias_adr('h20), dat, 8'h0f);
    endtask

    task automatic compare_stream(input string name);
        while (rx_q.size() < exp_q.size()) @(posedge clk);
        while (exp_q.size() > 0) begin
            expect_equal(name, 64'(exp_q.pop_front()), 64'(rx_q.pop_front()));
        end
        @(posedge clk);
        expect_equal({name, "_extra"}, 64'h0, 64'(rx_q.size()));
        expect_equal({name, "_valid"}, 64'h0, 64'(tx_valid));
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Console sink. Ready follows its own LFSR unless held low.
    always @(posedge clk) begin
        if (tx_valid && tx_ready) rx_q.push_back(tx_data);
        sink_lfsr = step_lfsr(sink_lfsr);
        tx_ready <= !hold_ready && reset && sink_lfsr[0];
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("*** FAILED ***");
            $fatal(1, "The tests did not finish within %0d cycles.", MAX_CYCLES);
        end
    end

    initial begin
        int        a;
        int        b;
        int        kind;
        host_adr_t adr;
        host_dat_t dat;
        host_dat_t rdat;
        host_sel_t sel;
        host_req   <= '0;
        tx_ready   <= 1'b0;
        hold_ready <= 1'b0;
        reset      <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;

        // RAM contents are not reset, so give every word a known value.
        for (int i = 0; i < 1024; i++) begin
            ram_model[i[9:0]] = {6'h15, i[9:0], 6'h2a, ~i[9:0]};
        end
        for (a = 'h200; a < 'h400; a++) begin
            write_word(alias_adr(a), {ram_model[ram_index(a, 1)], ram_model[ram_index(a, 0)]},
                       8'hff);
        end

        for (int n = 0; n < RAM_WRITES; n++) begin
            a   = 'h200 + pick_below(512);
            dat = take_bits(64);
            sel = host_sel_t'(take_bits(8));
            write_word(alias_adr(a), dat, sel);
            merge_write(a, dat, sel);
            written.push_back(a);
            sel = host_sel_t'(take_bits(8));
            read_word(alias_adr(a), sel, rdat);
            expect_equal("ram_same_adr", expected_read(a, sel), rdat);
            b   = written[pick_below(written.size())];
            sel = host_sel_t'(take_bits(8));
            read_word(alias_adr(b), sel, rdat);
            expect_equal("ram_earlier_adr", expected_read(b, sel), rdat);
        end

        a = 'h200 + pick_below(512);
        write_word(alias_adr(a), take_bits(64), 8'h00);
        read_word(alias_adr(a), 8'h00, rdat);
        expect_equal("zero_sel_read", 64'h0, rdat);
        read_word(alias_adr(a), 8'hff, rdat);
        expect_equal("zero_sel_unchanged", expected_read(a, 8'hff), rdat);

        for (int n = 0; n < CHARS; n++) send_char(char_t'(take_bits(8)));
        compare_stream("char_order");

        hold_ready <= 1'b1;
        repeat (2) @(posedge clk);
        for (int n = 0; n < 16; n++) send_char(char_t'(take_bits(8)));
        read_word(alias_adr('h20), 8'hf0, rdat);
        expect_equal("status_full", {status_word(expected_level()), 32'h0}, rdat);
        dat = take_bits(64);
        exp_q.push_back(dat[7:0]);
        start_access(alias_adr('h20), dat, 8'h0f, 1'b1);
        repeat (50) begin
            @(posedge clk);
            expect_equal("full_write_no_ack", 64'h0, 64'(host_rsp.ack));
        end
        hold_ready <= 1'b0;
        finish_access(rdat);
        compare_stream("char_after_stall");

        for (int n = 0; n < UNMAPPED; n++) begin
            kind = int'(take_bits(2));
            if (kind == 0) a = int'(take_bits(5));
            else if (kind == 1) a = 'h21 + pick_below('h1df);
            else a = 'h400 + pick_below('h7c00);   // Local words above the RAM window.
            read_word(alias_adr(a), 8'hff, rdat);
            expect_equal("unmapped_read", 64'h0, rdat);
            write_word(alias_adr(a), take_bits(64), 8'hff);
            b = 'h200 + a % 'h200;   // RAM word with the same low index bits.
            read_word(alias_adr(b), 8'hff, rdat);
            expect_equal("ram_after_unmapped", expected_read(b, 8'hff), rdat);
        end
        expect_equal("fifo_after_unmapped", 64'h0, 64'(rx_q.size()));

        a   = 'h200 + pick_below(512);
        adr = alias_adr(a);
        dat = take_bits(64);
        write_word(adr, dat, 8'hff);
        merge_write(a, dat, 8'hff);
        adr[36:15] = ~adr[36:15];
        read_word(adr, 8'hff, rdat);
        expect_equal("alias_read", expected_read(a, 8'hff), rdat);

        read_word(alias_adr('h20), 8'hf0, rdat);
        expect_equal("status_empty", {status_word(expected_level()), 32'h0}, rdat);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* hw/simple_controller_top.sv */
`timescale 1ns/10ps

module simple_controller_top (
    input  logic                   clk,
    input  logic                   reset,
    input  ctrl_pkg::host_wb_req_t host_req_i,
    output ctrl_pkg::host_wb_rsp_t host_rsp_o,
    output ctrl_pkg::char_t        tx_data_o,
    output logic                   tx_valid_o,
    input  logic                   tx_ready_i
);

    import ctrl_pkg::*;

    loc_wb_req_t loc_req;
    loc_wb_rsp_t loc_rsp;
    loc_wb_req_t ram_req;
    loc_wb_rsp_t ram_rsp;
    loc_wb_req_t con_req;
    loc_wb_rsp_t con_rsp;

    wb_downsizer u_bridge (
        .clk        (clk),
        .reset      (reset),
        .host_req_i (host_req_i),
        .host_rsp_o (host_rsp_o),
        .loc_req_o  (loc_req),
        .loc_rsp_i  (loc_rsp)
    );

    local_bus_decoder u_decoder (
        .loc_req_i (loc_req),
        .loc_rsp_o (loc_rsp),
        .ram_req_o (ram_req),
        .ram_rsp_i (ram_rsp),
        .con_req_o (con_req),
        .con_rsp_i (con_rsp),
        .clk       (clk),
        .reset     (reset)
    );

    local_ram u_ram (
        .clk   (clk),
        .reset (reset),
        .req_i (ram_req),
        .rsp_o (ram_rsp)
    );

    console_port u_console (
        .clk        (clk),
        .reset      (reset),
        .req_i      (con_req),
        .rsp_o      (con_rsp),
        .tx_data_o  (tx_data_o),
        .tx_valid_o (tx_valid_o),
        .tx_ready_i (tx_ready_i)
    );

endmodule

/* hw/wb_downsizer.sv */
`timescale 1ns/10ps

module wb_downsizer (
    input  logic                   clk,
    input  logic                   reset,
    input  ctrl_pkg::host_wb_req_t host_req_i,
    output ctrl_pkg::host_wb_rsp_t host_rsp_o,
    output ctrl_pkg::loc_wb_req_t  loc_req_o,
    input  ctrl_pkg::loc_wb_rsp_t  loc_rsp_i
);

    import ctrl_pkg::*;

    ds_state_t state_q;
    ds_state_t state_d;
    host_dat_t rdata_q;   // Read halves collected here.

    logic                     lo_en;
    logic                     hi_en;
    logic                     in_high;
    logic [HOST_ADR_USED-1:0] word_adr;

    // A half takes part only if some of its selects are set.
    assign lo_en = |host_req_i.sel[3:0];
    assign hi_en = |host_req_i.sel[7:4];

    assign in_high  = (state_q == ds_high);
    assign word_adr = host_req_i.adr[HOST_ADR_USED-1:0];   // Upper bits alias.

    always_comb begin
        state_d = state_q;
        case (state_q)
            ds_idle: begin
                if (host_req_i.stb) begin
                    if (lo_en) begin
                        state_d = ds_low;
                    end else if (hi_en) begin
                        state_d = ds_high;
                    end else begin
                        state_d = ds_done;   // Nothing selected, ack anyway.
                    end
                end
            end
            ds_low: begin
                if (loc_rsp_i.ack) begin
                    state_d = hi_en ? ds_high : ds_done;
                end
            end
            ds_high: begin
                if (loc_rsp_i.ack) begin
                    state_d = ds_done;
                end
            end
            ds_done: state_d = ds_idle;   // Host drops stb after its ack.
            default: state_d = ds_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state_q <= ds_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Skipped halves must read back as zero.
    always_ff @(posedge clk) begin
        if (state_q == ds_idle) begin
            rdata_q <= '0;
        end else if (state_q == ds_low && loc_rsp_i.ack) begin
            rdata_q[31:0] <= loc_rsp_i.dat;
        end else if (state_q == ds_high && loc_rsp_i.ack) begin
            rdata_q[63:32] <= loc_rsp_i.dat;
        end
    end

    // Host fields are stable during the whole access, so they feed through.
    always_comb begin
        loc_req_o.adr = {word_adr, in_high};                // Even word low, odd word high.
        loc_req_o.dat = in_high ? host_req_i.dat[63:32] : host_req_i.dat[31:0];
        loc_req_o.sel = in_high ? host_req_i.sel[7:4] : host_req_i.sel[3:0];
        loc_req_o.we  = host_req_i.we;
        loc_req_o.stb = (state_q == ds_low) || (state_q == ds_high);
    end

    assign host_rsp_o.dat = rdata_q;
    assign host_rsp_o.ack = (state_q == ds_done);

endmodule

/* hw/local_bus_decoder.sv */
`timescale 1ns/10ps

module local_bus_decoder (
    input  ctrl_pkg::loc_wb_req_t loc_req_i,
    output ctrl_pkg::loc_wb_rsp_t loc_rsp_o,
    output ctrl_pkg::loc_wb_req_t ram_req_o,
    input  ctrl_pkg::loc_wb_rsp_t ram_rsp_i,
    output ctrl_pkg::loc_wb_req_t con_req_o,
    input  ctrl_pkg::loc_wb_rsp_t con_rsp_i,
    input  logic                  clk,
    input  logic                  reset
);

    import ctrl_pkg::*;

    logic ram_hit;
    logic con_hit;
    logic dflt_ack_q;   // Answers unmapped addresses.

    assign ram_hit = (loc_req_i.adr[LOC_ADR_W-1:RAM_ADR_BITS] ==
                      RAM_BASE_ADR[LOC_ADR_W-1:RAM_ADR_BITS]);
    assign con_hit = (loc_req_i.adr == CONSOLE_DATA_ADR) ||
                     (loc_req_i.adr == CONSOLE_STAT_ADR);

    // Only the addressed target sees the strobe.
    always_comb begin
        ram_req_o     = loc_req_i;
        ram_req_o.stb = loc_req_i.stb && ram_hit;
        con_req_o     = loc_req_i;
        con_req_o.stb = loc_req_i.stb && con_hit;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            dflt_ack_q <= 1'b0;
        end else begin
            dflt_ack_q <= loc_req_i.stb && !ram_hit && !con_hit && !dflt_ack_q;
        end
    end

    // Address is held until ack, so it still selects the right response.
    always_comb begin
        if (ram_hit) begin
            loc_rsp_o = ram_rsp_i;
        end else if (con_hit) begin
            loc_rsp_o = con_rsp_i;
        end else begin
            loc_rsp_o.dat = '0;
            loc_rsp_o.ack = dflt_ack_q;
        end
    end

endmodule

/* hw/local_ram.sv */
`timescale 1ns/10ps

module local_ram (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrl_pkg::loc_wb_req_t req_i,
    output ctrl_pkg::loc_wb_rsp_t rsp_o
);

    import ctrl_pkg::*;

    loc_dat_t mem [RAM_WORDS];

    logic [RAM_ADR_BITS-1:0] idx;
    logic                    access;
    logic                    ack_q;
    loc_dat_t                rdat_q;

    assign idx = req_i.adr[RAM_ADR_BITS-1:0];

    // First cycle of a strobe only. The ack cycle does not count again.
    assign access = req_i.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (access && req_i.we) begin
            for (int b = 0; b < LOC_DAT_W / 8; b++) begin
                if (req_i.sel[b]) begin
                    mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                end
            end
        end
        if (access) begin
            rdat_q <= mem[idx];   // Old contents on a write.
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign rsp_o.dat = rdat_q;
    assign rsp_o.ack = ack_q;

endmodule

/* console/console_port.sv */
`timescale 1ns/10ps

module console_port (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrl_pkg::loc_wb_req_t req_i,
    output ctrl_pkg::loc_wb_rsp_t rsp_o,
    output ctrl_pkg::char_t       tx_data_o,
    output logic                  tx_valid_o,
    input  logic                  tx_ready_i
);

    import ctrl_pkg::*;

    logic        is_stat;
    logic        fifo_full;
    fifo_level_t fifo_level;
    logic        room;
    logic        first;
    logic        push;
    logic        ack_d;
    logic        ack_q;
    loc_dat_t    stat_word;
    loc_dat_t    rdat_q;

    // The decoder only strobes us for 0x40 or 0x41.
    assign is_stat = req_i.adr[0];

    // A full FIFO still has room when a byte leaves on the same edge.
    assign room  = !fifo_full || tx_ready_i;
    assign first = req_i.stb && !ack_q;

    assign push  = first && req_i.we && !is_stat && room;
    assign ack_d = first && (is_stat || !req_i.we || room);   // Stall data writes.

    always_comb begin
        stat_word                     = '0;
        stat_word[FIFO_LEVEL_W-1:0]   = fifo_level;
        stat_word[STAT_FULL_BIT]      = fifo_full;
        stat_word[STAT_EMPTY_BIT]     = (fifo_level == '0);
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= ack_d;
        end
    end

    always_ff @(posedge clk) begin
        if (first) begin
            rdat_q <= is_stat ? stat_word : '0;   // Data word reads as zero.
        end
    end

    assign rsp_o.dat = rdat_q;
    assign rsp_o.ack = ack_q;

    char_fifo u_fifo (
        .clk         (clk),
        .reset       (reset),
        .push_i      (push),
        .push_data_i (req_i.dat[7:0]),
        .full_o      (fifo_full),
        .level_o     (fifo_level),
        .pop_valid_o (tx_valid_o),
        .pop_data_o  (tx_data_o),
        .pop_ready_i (tx_ready_i)
    );

endmodule

/* console/char_fifo.sv */
`timescale 1ns/10ps

module char_fifo (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push_i,
    input  ctrl_pkg::char_t       push_data_i,
    output logic                  full_o,
    output ctrl_pkg::fifo_level_t level_o,
    output logic                  pop_valid_o,
    output ctrl_pkg::char_t       pop_data_o,
    input  logic                  pop_ready_i
);

    import ctrl_pkg::*;

    char_t mem [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    fifo_level_t           level_q;
    logic                  do_push;
    logic                  do_pop;

    assign full_o      = (level_q == fifo_level_t'(FIFO_DEPTH));
    assign pop_valid_o = (level_q != '0);
    assign pop_data_o  = mem[rd_ptr_q];
    assign level_o     = level_q;

    assign do_pop  = pop_valid_o && pop_ready_i;
    assign do_push = push_i && (!full_o || do_pop);   // Full plus pop still takes it.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // Pointers wrap on their own at the power of two depth.
    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;   // Both or neither.
            endcase
        end
    end

endmodule

/* common/ctrl_pkg.sv */
package ctrl_pkg;

    // Bus widths.
    localparam int HOST_ADR_W = 37;
    localparam int HOST_DAT_W = 64;
    localparam int LOC_ADR_W  = 16;
    localparam int LOC_DAT_W  = 32;

    typedef logic [HOST_ADR_W-1:0]   host_adr_t;
    typedef logic [HOST_DAT_W-1:0]   host_dat_t;
    typedef logic [HOST_DAT_W/8-1:0] host_sel_t;
    typedef logic [LOC_ADR_W-1:0]    loc_adr_t;
    typedef logic [LOC_DAT_W-1:0]    loc_dat_t;
    typedef logic [LOC_DAT_W/8-1:0]  loc_sel_t;

    // Console character and FIFO sizing.
    localparam int FIFO_DEPTH   = 16;
    localparam int FIFO_PTR_W   = 4;   // log2 of FIFO_DEPTH.
    localparam int FIFO_LEVEL_W = 5;   // Counts 0 to FIFO_DEPTH.

    typedef logic [7:0]              char_t;
    typedef logic [FIFO_LEVEL_W-1:0] fifo_level_t;

    // Local address map.
    localparam loc_adr_t CONSOLE_DATA_ADR = 16'h0040;
    localparam loc_adr_t CONSOLE_STAT_ADR = 16'h0041;
    localparam loc_adr_t RAM_BASE_ADR     = 16'h0400;
    localparam int       RAM_ADR_BITS     = 10;
    localparam int       RAM_WORDS        = 1 << RAM_ADR_BITS;

    // Low host word address bits that reach the local bus.
    localparam int HOST_ADR_USED = 15;

    // Console status word.
    localparam int STAT_FULL_BIT  = 8;
    localparam int STAT_EMPTY_BIT = 9;

    typedef struct packed {
        host_adr_t adr;
        host_dat_t dat;
        host_sel_t sel;
        logic      we;
        logic      stb;
    } host_wb_req_t;

    typedef struct packed {
        host_dat_t dat;
        logic      ack;
    } host_wb_rsp_t;

    typedef struct packed {
        loc_adr_t adr;
        loc_dat_t dat;
        loc_sel_t sel;
        logic     we;
        logic     stb;
    } loc_wb_req_t;

    typedef struct packed {
        loc_dat_t dat;
        logic     ack;
    } loc_wb_rsp_t;

    typedef enum logic [1:0] {ds_idle, ds_low, ds_high, ds_done} ds_state_t;

endpackage
